// ==== lb_defines.svh ====
// Local-bus width, depth and build-option macros; include in any file that uses them
`ifndef LB_DEFINES_SVH
`define LB_DEFINES_SVH

// Bus widths
`define LB_DATA_W        32
`define LB_ADDR_W        12
`define LB_CHLD_ADDR_W   8

// Upper address bits pick one of these blocks
`define LB_NUM_CHILDREN  2

// Read value for unmapped blocks and an empty mailbox
`define LB_DEFAULT_DATA  32'hdeadbabe

// Child sizes
`define LB_REG_DEPTH     16
`define LB_MBOX_DEPTH    8

// 1 adds a register stage on both sides of the splitter
`define LB_SPLIT_REG_OUT 0

`endif

// ==== lb_pkg.sv ====
// Local-bus request, response and address types shared by the RTL and the testbench
`include "lb_defines.svh"

package lb_pkg;

  // Master-side request, strobes are single-cycle
  typedef struct packed {
    logic                      wr_en;
    logic                      rd_en;
    logic [`LB_ADDR_W-1:0]     addr;
    logic [`LB_DATA_W-1:0]     wr_data;
  } lb_req_t;

  // Response, both valids are single-cycle pulses
  typedef struct packed {
    logic                      wr_valid;
    logic                      rd_valid;
    logic [`LB_DATA_W-1:0]     rd_data;
  } lb_rsp_t;

  // Child-side request after the block bits are stripped
  typedef struct packed {
    logic                      wr_en;
    logic                      rd_en;
    logic [`LB_CHLD_ADDR_W-1:0] addr;
    logic [`LB_DATA_W-1:0]     wr_data;
  } lb_chld_req_t;

  // Master address split into block number and child address
  typedef struct packed {
    logic [`LB_ADDR_W-`LB_CHLD_ADDR_W-1:0] blk;
    logic [`LB_CHLD_ADDR_W-1:0]            chld_addr;
  } lb_addr_t;

endpackage

// ==== lb_arbiter.sv ====
// Round-robin arbiter that puts two local-bus masters onto one shared bus, one transaction at a time
module lb_arbiter (
  input  logic            clk,
  input  logic            rst_n,
  input  lb_pkg::lb_req_t m0_req,
  input  lb_pkg::lb_req_t m1_req,
  output lb_pkg::lb_rsp_t m0_rsp,
  output lb_pkg::lb_rsp_t m1_rsp,
  output lb_pkg::lb_req_t bus_req,
  input  lb_pkg::lb_rsp_t bus_rsp
);
  import lb_pkg::*;

  lb_req_t    m_req [2];
  lb_req_t    pend_req [2];
  logic [1:0] m_strobe;
  logic [1:0] pend_vld;
  logic [1:0] issue_vec;
  logic       busy;
  logic       owner;
  logic       last_served;
  logic       issue;
  logic       grant;
  logic       rsp_vld;

  // Masters as an array so the slots share one loop
  assign m_req[0] = m0_req;
  assign m_req[1] = m1_req;

  for (genvar i = 0; i < 2; i++)
  begin : g_strobe
    assign m_strobe[i] = m_req[i].wr_en | m_req[i].rd_en;
  end

  // Master 1 wins unless master 0 waits and master 1 went last
  assign grant     = pend_vld[1] & (~pend_vld[0] | ~last_served);
  assign issue     = ~busy & (|pend_vld);
  assign issue_vec = issue ? {grant, ~grant} : 2'b00;
  assign rsp_vld   = bus_rsp.wr_valid | bus_rsp.rd_valid;

  // Pending flags, set by a strobe and cleared once issued
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_vld <= 2'b00;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        if (m_strobe[i])
          pend_vld[i] <= 1'b1;
        else if (issue_vec[i])
          pend_vld[i] <= 1'b0;
      end
    end
  end

  // Slot payload, only meaningful while its flag is set
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (m_strobe[i])
        pend_req[i] <= m_req[i];
    end
  end

  // Busy from issue until the shared response
  // Reset leaves master 1 as last served so master 0 goes first
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy        <= 1'b0;
      owner       <= 1'b0;
      last_served <= 1'b1;
    end
    else if (issue)
    begin
      busy        <= 1'b1;
      owner       <= grant;
      last_served <= grant;
    end
    else if (rsp_vld)
    begin
      busy <= 1'b0;
    end
  end

  // Shared request only in the issue cycle
  always_comb
  begin
    bus_req = '0;
    if (issue)
      bus_req = pend_req[grant];
  end

  // Response goes back to its owner in the same cycle
  always_comb
  begin
    m0_rsp = '0;
    m1_rsp = '0;
    if (rsp_vld)
    begin
      if (owner)
        m1_rsp = bus_rsp;
      else
        m0_rsp = bus_rsp;
    end
  end

  // Masters wait for their own valid before the next strobe
  for (genvar i = 0; i < 2; i++)
  begin : g_chk
    a_no_strobe_pending: assert property (@(posedge clk) disable iff (!rst_n)
      m_strobe[i] |-> !pend_vld[i]);
  end

  // Shared bus answers only an issued transaction
  a_no_rsp_idle: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_vld |-> busy);

endmodule

// ==== lb_splitter.sv ====
// Local-bus address decoder that routes shared-bus transactions to child blocks and merges replies
`include "lb_defines.svh"

module lb_splitter #(
  parameter bit REGISTER_OUTPUTS = `LB_SPLIT_REG_OUT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  lb_pkg::lb_req_t      bus_req,
  output lb_pkg::lb_rsp_t      bus_rsp,
  output lb_pkg::lb_chld_req_t chld_req [`LB_NUM_CHILDREN],
  input  lb_pkg::lb_rsp_t      chld_rsp [`LB_NUM_CHILDREN]
);
  import lb_pkg::*;

  localparam int NCH   = `LB_NUM_CHILDREN;
  localparam int BLK_W = `LB_ADDR_W - `LB_CHLD_ADDR_W;

  lb_req_t        req_s;
  lb_addr_t       addr_s;
  lb_rsp_t        rsp_nxt;
  logic [NCH-1:0] sel_s;
  logic [NCH-1:0] sel_q;
  logic [NCH-1:0] chld_vld;
  logic           dflt_wr;
  logic           dflt_rd;

  if (REGISTER_OUTPUTS)
  begin : g_reg
    logic                  wr_en_q;
    logic                  rd_en_q;
    logic [`LB_ADDR_W-1:0] addr_q;
    logic [`LB_DATA_W-1:0] wr_data_q;
    logic                  wr_vld_q;
    logic                  rd_vld_q;
    logic [`LB_DATA_W-1:0] rd_data_q;

    // Strobes and valids reset, payload follows them
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        wr_en_q  <= 1'b0;
        rd_en_q  <= 1'b0;
        wr_vld_q <= 1'b0;
        rd_vld_q <= 1'b0;
      end
      else
      begin
        wr_en_q  <= bus_req.wr_en;
        rd_en_q  <= bus_req.rd_en;
        wr_vld_q <= rsp_nxt.wr_valid;
        rd_vld_q <= rsp_nxt.rd_valid;
      end
    end

    always_ff @(posedge clk)
    begin
      addr_q    <= bus_req.addr;
      wr_data_q <= bus_req.wr_data;
      rd_data_q <= rsp_nxt.rd_data;
    end

    assign req_s   = '{wr_en: wr_en_q, rd_en: rd_en_q, addr: addr_q, wr_data: wr_data_q};
    assign bus_rsp = '{wr_valid: wr_vld_q, rd_valid: rd_vld_q, rd_data: rd_data_q};
  end
  else
  begin : g_comb
    assign req_s   = bus_req;
    assign bus_rsp = rsp_nxt;
  end

  assign addr_s = lb_addr_t'(req_s.addr);

  // One-hot select; enables go only to the selected child
  for (genvar i = 0; i < NCH; i++)
  begin : g_child
    assign sel_s[i]    = (addr_s.blk == BLK_W'(i));
    assign chld_req[i] = '{wr_en:   req_s.wr_en & sel_s[i],
                           rd_en:   req_s.rd_en & sel_s[i],
                           addr:    addr_s.chld_addr,
                           wr_data: req_s.wr_data};
    assign chld_vld[i] = chld_rsp[i].wr_valid | chld_rsp[i].rd_valid;
  end

  // Select of the outstanding access, plus own reply for unmapped blocks
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sel_q   <= '0;
      dflt_wr <= 1'b0;
      dflt_rd <= 1'b0;
    end
    else
    begin
      dflt_wr <= req_s.wr_en & ~(|sel_s);
      dflt_rd <= req_s.rd_en & ~(|sel_s);
      if (req_s.wr_en | req_s.rd_en)
        sel_q <= sel_s;
    end
  end

  // OR of child valids, read data masked by the held select
  always_comb
  begin
    rsp_nxt.wr_valid = dflt_wr;
    rsp_nxt.rd_valid = dflt_rd;
    rsp_nxt.rd_data  = (sel_q == '0) ? `LB_DEFAULT_DATA : '0;
    for (int n = 0; n < NCH; n++)
    begin
      rsp_nxt.wr_valid = rsp_nxt.wr_valid | chld_rsp[n].wr_valid;
      rsp_nxt.rd_valid = rsp_nxt.rd_valid | chld_rsp[n].rd_valid;
      rsp_nxt.rd_data  = rsp_nxt.rd_data | (chld_rsp[n].rd_data & {`LB_DATA_W{sel_q[n]}});
    end
  end

  // Children only answer the single outstanding access
  a_one_child_vld: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(chld_vld));

endmodule

// ==== lb_reg_bank.sv ====
// Local-bus child holding read/write 32-bit control registers; mapped as block 0
`include "lb_defines.svh"

module lb_reg_bank (
  input  logic                 clk,
  input  logic                 rst_n,
  input  lb_pkg::lb_chld_req_t chld_req,
  output lb_pkg::lb_rsp_t      chld_rsp
);

  localparam int IDX_W = $clog2(`LB_REG_DEPTH);

  logic [`LB_DATA_W-1:0] regs [`LB_REG_DEPTH];
  logic [IDX_W-1:0]      idx;
  logic                  wr_vld_q;
  logic                  rd_vld_q;
  logic [`LB_DATA_W-1:0] rd_data_q;

  // Low address bits only, upper bits alias
  assign idx = chld_req.addr[IDX_W-1:0];

  // Registers clear to zero
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `LB_REG_DEPTH; i++)
        regs[i] <= '0;
    end
    else if (chld_req.wr_en)
    begin
      regs[idx] <= chld_req.wr_data;
    end
  end

  // Every strobe answered one cycle later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_vld_q <= 1'b0;
      rd_vld_q <= 1'b0;
    end
    else
    begin
      wr_vld_q <= chld_req.wr_en;
      rd_vld_q <= chld_req.rd_en;
    end
  end

  always_ff @(posedge clk)
  begin
    if (chld_req.rd_en)
      rd_data_q <= regs[idx];
  end

  assign chld_rsp = '{wr_valid: wr_vld_q, rd_valid: rd_vld_q, rd_data: rd_data_q};

endmodule

// ==== lb_mailbox.sv ====
// Local-bus mailbox FIFO child with push/pop data port and fill-level register; mapped as block 1
`include "lb_defines.svh"

module lb_mailbox (
  input  logic                 clk,
  input  logic                 rst_n,
  input  lb_pkg::lb_chld_req_t chld_req,
  output lb_pkg::lb_rsp_t      chld_rsp
);

  localparam int PTR_W = $clog2(`LB_MBOX_DEPTH);
  localparam int LVL_W = $clog2(`LB_MBOX_DEPTH + 1);

  logic [`LB_DATA_W-1:0] mem [`LB_MBOX_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [LVL_W-1:0]      level;
  logic                  full;
  logic                  empty;
  logic                  data_port;
  logic                  lvl_port;
  logic                  push;
  logic                  pop;
  logic                  wr_vld_q;
  logic                  rd_vld_q;
  logic [`LB_DATA_W-1:0] rd_data_q;
  logic [`LB_DATA_W-1:0] rd_data_nxt;

  // Address 0 data port, address 1 fill level
  assign data_port = (chld_req.addr == '0);
  assign lvl_port  = (chld_req.addr == `LB_CHLD_ADDR_W'(1));
  assign full      = (level == LVL_W'(`LB_MBOX_DEPTH));
  assign empty     = (level == '0);

  // Push when full and pop when empty do nothing
  assign push = chld_req.wr_en & data_port & ~full;
  assign pop  = chld_req.rd_en & data_port & ~empty;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(`LB_MBOX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(`LB_MBOX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Strobes never overlap, so no simultaneous push and pop
      if (push)
        level <= level + 1'b1;
      else if (pop)
        level <= level - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= chld_req.wr_data;
  end

  // Read mux; other addresses read zero
  always_comb
  begin
    rd_data_nxt = '0;
    if (data_port)
      rd_data_nxt = empty ? `LB_DEFAULT_DATA : mem[rd_ptr];
    else if (lvl_port)
      rd_data_nxt = `LB_DATA_W'(level);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_vld_q <= 1'b0;
      rd_vld_q <= 1'b0;
    end
    else
    begin
      wr_vld_q <= chld_req.wr_en;
      rd_vld_q <= chld_req.rd_en;
    end
  end

  always_ff @(posedge clk)
  begin
    if (chld_req.rd_en)
      rd_data_q <= rd_data_nxt;
  end

  assign chld_rsp = '{wr_valid: wr_vld_q, rd_valid: rd_vld_q, rd_data: rd_data_q};

  // Level tracks pushes minus pops over the whole run
  a_level_max: assert property (@(posedge clk) disable iff (!rst_n)
    (level <= LVL_W'(`LB_MBOX_DEPTH)) &&
    (((int'(wr_ptr) - int'(rd_ptr) + `LB_MBOX_DEPTH) % `LB_MBOX_DEPTH) ==
     (int'(level) % `LB_MBOX_DEPTH)));

endmodule

// ==== lb_subsystem_top.sv ====
// Local-bus register subsystem top; connects two masters through arbiter and splitter to both children
`include "lb_defines.svh"

module lb_subsystem_top (
  input  logic            clk,
  input  logic            rst_n,
  input  lb_pkg::lb_req_t m0_req,
  input  lb_pkg::lb_req_t m1_req,
  output lb_pkg::lb_rsp_t m0_rsp,
  output lb_pkg::lb_rsp_t m1_rsp
);
  import lb_pkg::*;

  // Shared bus between arbiter and splitter
  lb_req_t      bus_req;
  lb_rsp_t      bus_rsp;

  // Block 0 register bank, block 1 mailbox
  lb_chld_req_t chld_req [`LB_NUM_CHILDREN];
  lb_rsp_t      chld_rsp [`LB_NUM_CHILDREN];

  lb_arbiter u_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .m0_req  (m0_req),
    .m1_req  (m1_req),
    .m0_rsp  (m0_rsp),
    .m1_rsp  (m1_rsp),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  lb_splitter #(
    .REGISTER_OUTPUTS (`LB_SPLIT_REG_OUT)
  ) u_splitter (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .chld_req (chld_req),
    .chld_rsp (chld_rsp)
  );

  lb_reg_bank u_reg_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .chld_req (chld_req[0]),
    .chld_rsp (chld_rsp[0])
  );

  lb_mailbox u_mailbox (
    .clk      (clk),
    .rst_n    (rst_n),
    .chld_req (chld_req[1]),
    .chld_rsp (chld_rsp[1])
  );

endmodule

// ==== tb_lb_subsystem.sv ====
// Self-checking testbench for the local-bus subsystem; two random masters checked against a model
`include "lb_defines.svh"

module tb_lb_subsystem;
  import lb_pkg::*;

  localparam int NUM_TXN  = 300;
  localparam int RSP_WAIT = 40;

  logic    clk;
  logic    rst_n;
  lb_req_t m0_req;
  lb_req_t m1_req;
  lb_rsp_t m0_rsp;
  lb_rsp_t m1_rsp;

  // Reference model of block 0 and block 1
  logic [`LB_DATA_W-1:0] reg_model [`LB_REG_DEPTH];
  logic [`LB_DATA_W-1:0] mbox_model [$];

  // Per-master bookkeeping
  logic    busy_m [2];
  lb_req_t cur_req [2];
  int      strobe_cyc [2];
  int      cycle;
  int      last_rsp;
  int      pair_cnt;
  int      fail_cnt;

  lb_subsystem_top UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .m0_req (m0_req),
    .m1_req (m1_req),
    .m0_rsp (m0_rsp),
    .m1_rsp (m1_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Cycle stamp for same-cycle strobe detection
  always @(posedge clk)
    cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  // Valid bits of a response
  task automatic compare_rsp(input string name, input lb_rsp_t got, input lb_rsp_t exp);
    if (got.wr_valid !== exp.wr_valid || got.rd_valid !== exp.rd_valid)
      abort_run($sformatf("error at %0t: %s valids got wr=%b rd=%b expected wr=%b rd=%b",
                          $time, name, got.wr_valid, got.rd_valid,
                          exp.wr_valid, exp.rd_valid));
  endtask

  task automatic compare_data(input string name, input logic [`LB_DATA_W-1:0] got,
                              input logic [`LB_DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic drive_req(input int m, input lb_req_t req);
    if (m == 0)
      m0_req = req;
    else
      m1_req = req;
  endtask

  // Apply the outstanding request to the model and check the reply
  task automatic check_response(input int m, input lb_rsp_t got);
    lb_req_t  req;
    lb_addr_t a;
    lb_rsp_t  exp;
    string    name;
    req          = cur_req[m];
    a            = lb_addr_t'(req.addr);
    name         = $sformatf("m%0d_rsp", m);
    exp          = '0;
    exp.wr_valid = req.wr_en;
    exp.rd_valid = req.rd_en;
    if (a.blk == 0)
    begin
      // Low 4 address bits pick the register
      if (req.wr_en)
        reg_model[a.chld_addr[3:0]] = req.wr_data;
      else
        exp.rd_data = reg_model[a.chld_addr[3:0]];
    end
    else if (a.blk == 1)
    begin
      if (a.chld_addr == 0)
      begin
        // Full FIFO drops a push and empty FIFO pops the default word
        if (req.wr_en)
        begin
          if (mbox_model.size() < `LB_MBOX_DEPTH)
            mbox_model.push_back(req.wr_data);
        end
        else if (mbox_model.size() == 0)
          exp.rd_data = `LB_DEFAULT_DATA;
        else
          exp.rd_data = mbox_model.pop_front();
      end
      else if (a.chld_addr == 1)
        exp.rd_data = mbox_model.size();
    end
    else
    begin
      exp.rd_data = `LB_DEFAULT_DATA;
    end
    compare_rsp(name, got, exp);
    if (req.rd_en)
      compare_data({name, ".rd_data"}, got.rd_data, exp.rd_data);
  endtask

  task automatic watch_port(input int m, input lb_rsp_t rsp);
    if (rsp.wr_valid || rsp.rd_valid)
    begin
      if (!busy_m[m])
        abort_run($sformatf("master %0d got a response with no request outstanding", m));
      // With joint strobes the master not served last answers first
      if (busy_m[1-m] && strobe_cyc[1-m] == strobe_cyc[m])
      begin
        pair_cnt++;
        if (m == last_rsp)
          abort_run($sformatf("master %0d was served first out of round-robin order", m));
      end
      check_response(m, rsp);
      busy_m[m] = 1'b0;
      last_rsp  = m;
    end
  endtask

  // Outputs sampled mid-cycle even during reset
  always @(negedge clk)
  begin
    if ((m0_rsp.wr_valid || m0_rsp.rd_valid) && (m1_rsp.wr_valid || m1_rsp.rd_valid))
      abort_run("both masters got a response in the same cycle");
    watch_port(0, m0_rsp);
    watch_port(1, m1_rsp);
  end

  // Random gap and one strobe per step, then wait for the master's own pulse
  task automatic run_master(input int m);
    logic [31:0] st;
    lb_req_t     req;
    lb_addr_t    a;
    lb_rsp_t     rsp;
    int          gap;
    int          wait_cnt;
    bit          got;
    st = 32'd57;
    // Master 1 runs one step ahead in the same sequence
    if (m == 1)
      st = lcg_next(st);
    for (int n = 0; n < NUM_TXN; n++)
    begin
      st  = lcg_next(st);
      gap = (n == 0) ? 0 : st[31:30];
      st  = lcg_next(st);
      req = '0;
      a   = '0;
      // Write-heavy first half fills the mailbox and read-heavy second half drains it
      if (st[31:28] < ((n < NUM_TXN / 2) ? 4'd11 : 4'd5))
        req.wr_en = 1'b1;
      else
        req.rd_en = 1'b1;
      if (st[27:25] < 3'd3)
      begin
        a.blk       = 4'd0;
        a.chld_addr = st[20:13];
      end
      else if (st[27:25] < 3'd7)
      begin
        a.blk       = 4'd1;
        a.chld_addr = (st[20:18] < 3'd4) ? 8'd0 : (st[20:18] < 3'd6) ? 8'd1 : st[15:8];
      end
      else
      begin
        a.blk       = 4'd2 + 4'(st[24:21] % 14);
        a.chld_addr = st[20:13];
      end
      req.addr    = a;
      st          = lcg_next(st);
      req.wr_data = st;
      repeat (gap) @(posedge clk);
      @(posedge clk);
      #1;
      drive_req(m, req);
      cur_req[m]    = req;
      strobe_cyc[m] = cycle;
      busy_m[m]     = 1'b1;
      @(posedge clk);
      #1;
      drive_req(m, '0);
      got      = 1'b0;
      wait_cnt = 0;
      while (!got)
      begin
        @(negedge clk);
        rsp = (m == 0) ? m0_rsp : m1_rsp;
        got = rsp.wr_valid | rsp.rd_valid;
        wait_cnt++;
        if (!got && wait_cnt > RSP_WAIT)
          abort_run($sformatf("master %0d timed out waiting for its response", m));
      end
    end
  endtask

  initial
  begin
    m0_req    = '0;
    m1_req    = '0;
    rst_n     = 1'b0;
    cycle     = 0;
    last_rsp  = 1;
    pair_cnt  = 0;
    fail_cnt  = 0;
    busy_m[0] = 1'b0;
    busy_m[1] = 1'b0;
    for (int i = 0; i < `LB_REG_DEPTH; i++)
      reg_model[i] = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Both first strobes land in the same cycle
    fork
      run_master(0);
      run_master(1);
    join
    // Room for any stray pulse
    repeat (4) @(negedge clk);
    // The first pair is forced, later pairs check the round-robin turn
    if (pair_cnt < 2)
    begin
      $display("no joint strobe from both masters was seen after the first one");
      fail_cnt++;
    end
    if (fail_cnt == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+.
lb_pkg.sv
lb_arbiter.sv
lb_splitter.sv
lb_reg_bank.sv
lb_mailbox.sv
lb_subsystem_top.sv
tb_lb_subsystem.sv

// ==== Bender.yml ====
package:
  name: lb_subsystem

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lb_pkg.sv
      - lb_arbiter.sv
      - lb_splitter.sv
      - lb_reg_bank.sv
      - lb_mailbox.sv
      - lb_subsystem_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_lb_subsystem.sv
